// ==== hw/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data and address width
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_REG_COUNT 32

// Bits needed to index one register
`define RV_REG_AW 5

`endif

// ==== hw/rv_isa_pkg.sv ====
`include "rv_defs.svh"

package rv_isa_pkg;

    // Datapath word and register index
    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    // Raw instruction word, always 32 bits in RV32I
    typedef logic [31:0] instr_t;

    // Instruction fields
    typedef logic [2:0] funct3_t;

    // Major opcodes handled by this slice
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10
    } alu_op_e;

endpackage

// ==== hw/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    import rv_isa_pkg::*;

    // One fetched instruction with its pc
    typedef struct packed {
        word_t  pc;
        instr_t instr;
    } fetch_pkt_t;

    // Control fields produced by decode
    typedef struct packed {
        logic    reg_wr_en;
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    alu_src_pc;
        logic    illegal;
        funct3_t funct3;
    } de_ctrl_t;

    // Decode-to-execute record
    typedef struct packed {
        logic      valid;
        de_ctrl_t  ctrl;
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rd_addr;
        word_t     imm;
    } de_pkt_t;

    // Result handed to writeback
    typedef struct packed {
        word_t     pc;
        reg_addr_t rd_addr;
        word_t     value;
        logic      wr_en;
        logic      illegal;
    } wb_pkt_t;

endpackage

// ==== hw/rv_decoder.sv ====
module rv_decoder (
    input  rv_isa_pkg::instr_t     instr_i,
    output rv_pipe_pkg::de_ctrl_t  ctrl_o,
    output rv_isa_pkg::word_t      imm_o,
    output rv_isa_pkg::reg_addr_t  rs1_addr_o,
    output rv_isa_pkg::reg_addr_t  rs2_addr_o,
    output rv_isa_pkg::reg_addr_t  rd_addr_o
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    funct3_t    funct3;
    logic [6:0] funct7;
    logic       funct7_zero;
    logic       funct7_alt;
    alu_op_e    base_op;
    logic       bad;

    assign funct3      = instr_i[14:12];
    assign funct7      = instr_i[31:25];
    assign funct7_zero = (funct7 == 7'b0000000);
    // SUB and SRA variant
    assign funct7_alt  = (funct7 == 7'b0100000);

    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];
    assign rd_addr_o  = instr_i[11:7];

    // funct3 mapping shared by OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b000:  base_op = ADD;
            3'b001:  base_op = SLL;
            3'b010:  base_op = SLT;
            3'b011:  base_op = SLTU;
            3'b100:  base_op = XOR;
            3'b101:  base_op = SRL;
            3'b110:  base_op = OR;
            default: base_op = AND;
        endcase
    end

    always_comb begin
        ctrl_o.alu_op      = ADD;
        ctrl_o.alu_src_imm = 1'b0;
        ctrl_o.alu_src_pc  = 1'b0;
        ctrl_o.funct3      = funct3;
        imm_o              = '0;
        bad                = 1'b0;
        case (opcode_e'(instr_i[6:0]))
            OP: begin
                if (funct7_zero) begin
                    ctrl_o.alu_op = base_op;
                end else if (funct7_alt && funct3 == 3'b000) begin
                    ctrl_o.alu_op = SUB;
                end else if (funct7_alt && funct3 == 3'b101) begin
                    ctrl_o.alu_op = SRA;
                end else begin
                    bad = 1'b1;
                end
            end
            OP_IMM: begin
                // I-type, sign extended
                imm_o              = {{20{instr_i[31]}}, instr_i[31:20]};
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_op      = base_op;
                // Shift immediates carry funct7 in the upper bits
                if (funct3 == 3'b001 && !funct7_zero) begin
                    bad = 1'b1;
                end else if (funct3 == 3'b101) begin
                    if (funct7_alt) begin
                        ctrl_o.alu_op = SRA;
                    end else if (!funct7_zero) begin
                        bad = 1'b1;
                    end
                end
            end
            LUI: begin
                imm_o              = {instr_i[31:12], 12'b0};
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_op      = PASS_B;
            end
            AUIPC: begin
                // pc plus upper immediate
                imm_o              = {instr_i[31:12], 12'b0};
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.alu_src_pc  = 1'b1;
                ctrl_o.alu_op      = ADD;
            end
            default: bad = 1'b1;
        endcase
        ctrl_o.illegal = bad;
        // No write for illegal encodings or rd of x0
        ctrl_o.reg_wr_en = !bad && (rd_addr_o != '0);
    end

endmodule

// ==== hw/rv_regfile.sv ====
`include "rv_defs.svh"

module rv_regfile (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  rv_isa_pkg::reg_addr_t  rd_addr_a_i,
    input  rv_isa_pkg::reg_addr_t  rd_addr_b_i,
    output rv_isa_pkg::word_t      rd_data_a_o,
    output rv_isa_pkg::word_t      rd_data_b_o,
    input  logic                   wr_en_i,
    input  rv_isa_pkg::reg_addr_t  wr_addr_i,
    input  rv_isa_pkg::word_t      wr_data_i
);
    import rv_isa_pkg::*;

    // x0 has no storage
    word_t regs [1:`RV_REG_COUNT-1];

    // One read port, with write-through of a same-cycle write
    function automatic word_t read_port(reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_en_i && (wr_addr_i == addr)) begin
            value = wr_data_i;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // All registers read zero after reset
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    always_comb begin
        rd_data_a_o = read_port(rd_addr_a_i);
        rd_data_b_o = read_port(rd_addr_b_i);
    end

    // Decode drops wr_en for rd of x0, so x0 writes never reach here
    a_no_x0_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wr_en_i |-> (wr_addr_i != '0));

endmodule

// ==== hw/rv_pipe_reg_d_e.sv ====
module rv_pipe_reg_d_e (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   advance_i,
    input  logic                   valid_i,
    input  rv_pipe_pkg::de_ctrl_t  ctrl_i,
    input  rv_isa_pkg::word_t      pc_i,
    input  rv_isa_pkg::word_t      rs1_data_i,
    input  rv_isa_pkg::word_t      rs2_data_i,
    input  rv_isa_pkg::reg_addr_t  rs1_addr_i,
    input  rv_isa_pkg::reg_addr_t  rs2_addr_i,
    input  rv_isa_pkg::reg_addr_t  rd_addr_i,
    input  rv_isa_pkg::word_t      imm_i,
    output rv_pipe_pkg::de_pkt_t   pkt_o
);
    import rv_pipe_pkg::*;

    logic    valid_q;
    de_pkt_t data_q;

    // Valid bit, cleared on a bubble
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (advance_i) begin
            valid_q <= valid_i;
        end
    end

    // Payload, held while advance is low
    always_ff @(posedge clk_i) begin
        if (advance_i) begin
            data_q.valid    <= valid_i;
            data_q.ctrl     <= ctrl_i;
            // Bubble drops the register write
            data_q.ctrl.reg_wr_en <= valid_i && ctrl_i.reg_wr_en;
            data_q.pc       <= pc_i;
            data_q.rs1_data <= rs1_data_i;
            data_q.rs2_data <= rs2_data_i;
            data_q.rs1_addr <= rs1_addr_i;
            data_q.rs2_addr <= rs2_addr_i;
            data_q.rd_addr  <= rd_addr_i;
            data_q.imm      <= imm_i;
        end
    end

    always_comb begin
        pkt_o       = data_q;
        pkt_o.valid = valid_q;
    end

    // An empty slot never carries a register write
    a_bubble_no_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !pkt_o.valid |-> !pkt_o.ctrl.reg_wr_en);

endmodule

// ==== hw/rv_alu.sv ====
module rv_alu (
    input  rv_isa_pkg::alu_op_e  op_i,
    input  rv_isa_pkg::word_t    a_i,
    input  rv_isa_pkg::word_t    b_i,
    output rv_isa_pkg::word_t    y_o
);
    import rv_isa_pkg::*;

    logic [4:0] shamt;

    // Shift amount from the low five bits
    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ADD:  y_o = a_i + b_i;
            SUB:  y_o = a_i - b_i;
            SLL:  y_o = a_i << shamt;
            // Compares give 0 or 1
            SLT:  y_o = {{($bits(word_t)-1){1'b0}}, ($signed(a_i) < $signed(b_i))};
            SLTU: y_o = {{($bits(word_t)-1){1'b0}}, (a_i < b_i)};
            XOR:  y_o = a_i ^ b_i;
            SRL:  y_o = a_i >> shamt;
            SRA:  y_o = word_t'($signed(a_i) >>> shamt);
            OR:   y_o = a_i | b_i;
            AND:  y_o = a_i & b_i;
            // LUI path
            PASS_B: y_o = b_i;
            default: y_o = '0;
        endcase
    end

endmodule

// ==== hw/rv_execute.sv ====
module rv_execute (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  rv_pipe_pkg::de_pkt_t   pkt_i,
    output logic                   advance_o,
    output rv_pipe_pkg::wb_pkt_t   res_o,
    output logic                   res_valid_o,
    input  logic                   res_ready_i,
    output logic                   rf_wr_en_o,
    output rv_isa_pkg::reg_addr_t  rf_wr_addr_o,
    output rv_isa_pkg::word_t      rf_wr_data_o
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    wb_pkt_t res_q;
    logic    res_valid_q;
    logic    take;
    logic    fwd_valid;
    word_t   rs1_val;
    word_t   rs2_val;
    word_t   op_a;
    word_t   op_b;
    word_t   alu_y;

    // Output handshake and stage advance
    assign take      = res_valid_q && res_ready_i;
    assign advance_o = !res_valid_q || res_ready_i;

    // Forward from the output register when it holds a pending write
    assign fwd_valid = res_valid_q && res_q.wr_en;
    assign rs1_val   = (fwd_valid && res_q.rd_addr == pkt_i.rs1_addr) ? res_q.value
                                                                      : pkt_i.rs1_data;
    assign rs2_val   = (fwd_valid && res_q.rd_addr == pkt_i.rs2_addr) ? res_q.value
                                                                      : pkt_i.rs2_data;

    // Operand selects
    assign op_a = pkt_i.ctrl.alu_src_pc  ? pkt_i.pc  : rs1_val;
    assign op_b = pkt_i.ctrl.alu_src_imm ? pkt_i.imm : rs2_val;

    rv_alu i_alu (
        .op_i (pkt_i.ctrl.alu_op),
        .a_i  (op_a),
        .b_i  (op_b),
        .y_o  (alu_y)
    );

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_valid_q <= 1'b0;
        end else if (advance_o) begin
            res_valid_q <= pkt_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance_o && pkt_i.valid) begin
            res_q.pc      <= pkt_i.pc;
            res_q.rd_addr <= pkt_i.ctrl.reg_wr_en ? pkt_i.rd_addr : '0;
            // Illegal results report a zero value
            res_q.value   <= pkt_i.ctrl.illegal ? '0 : alu_y;
            res_q.wr_en   <= pkt_i.ctrl.reg_wr_en;
            res_q.illegal <= pkt_i.ctrl.illegal;
        end
    end

    assign res_o       = res_q;
    assign res_valid_o = res_valid_q;

    // Register file write on the output handshake
    assign rf_wr_en_o   = take && res_q.wr_en;
    assign rf_wr_addr_o = res_q.rd_addr;
    assign rf_wr_data_o = res_q.value;

    // Offered result holds until taken
    a_res_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (res_valid_o && !res_ready_i) |=> res_valid_o && $stable(res_o));

endmodule

// ==== hw/rv_dx_top.sv ====
module rv_dx_top (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  rv_pipe_pkg::fetch_pkt_t  instr_i,
    input  logic                     instr_valid_i,
    output logic                     instr_ready_o,
    output rv_pipe_pkg::wb_pkt_t     res_o,
    output logic                     res_valid_o,
    input  logic                     res_ready_i
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    // Decode outputs
    de_ctrl_t  dec_ctrl;
    word_t     dec_imm;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    // Register file
    word_t     rs1_data;
    word_t     rs2_data;
    logic      rf_wr_en;
    reg_addr_t rf_wr_addr;
    word_t     rf_wr_data;
    // Pipeline register and advance
    de_pkt_t   de_pkt;
    logic      advance;

    assign instr_ready_o = advance;

    rv_decoder i_decoder (
        .instr_i    (instr_i.instr),
        .ctrl_o     (dec_ctrl),
        .imm_o      (dec_imm),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_addr_o  (rd_addr)
    );

    rv_regfile i_regfile (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .rd_addr_a_i (rs1_addr),
        .rd_addr_b_i (rs2_addr),
        .rd_data_a_o (rs1_data),
        .rd_data_b_o (rs2_data),
        .wr_en_i     (rf_wr_en),
        .wr_addr_i   (rf_wr_addr),
        .wr_data_i   (rf_wr_data)
    );

    rv_pipe_reg_d_e i_pipe_reg_d_e (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .advance_i  (advance),
        .valid_i    (instr_valid_i),
        .ctrl_i     (dec_ctrl),
        .pc_i       (instr_i.pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rd_addr_i  (rd_addr),
        .imm_i      (dec_imm),
        .pkt_o      (de_pkt)
    );

    rv_execute i_execute (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .pkt_i        (de_pkt),
        .advance_o    (advance),
        .res_o        (res_o),
        .res_valid_o  (res_valid_o),
        .res_ready_i  (res_ready_i),
        .rf_wr_en_o   (rf_wr_en),
        .rf_wr_addr_o (rf_wr_addr),
        .rf_wr_data_o (rf_wr_data)
    );

endmodule

// ==== sim/tb_clkgen.sv ====
module tb_clkgen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic arst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Release a quarter period after an edge, away from the flops
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #(PERIOD / 4);
        arst_n_o = 1'b1;
    end
endmodule

// ==== sim/tb_rv_dx.sv ====
module tb_rv_dx;
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam int DRIVE_DELAY = 10;
    localparam int WAIT_LIMIT  = 200;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    logic       clk;
    logic       arst_n;
    fetch_pkt_t instr;
    logic       instr_valid;
    logic       instr_ready;
    wb_pkt_t    res;
    logic       res_valid;
    logic       res_ready;

    // Expected results in program order
    wb_pkt_t    exp_q[$];
    word_t      model_regs [0:31];
    logic [31:0] lfsr = 32'h823a5811;
    word_t      pc_next = 32'h0000_1000;
    logic       gaps_on = 1'b0;
    logic       stalls_on = 1'b0;
    logic       prev_stall = 1'b0;
    wb_pkt_t    prev_res;

    tb_clkgen #(.PERIOD(100), .RESET_CYCLES(16)) i_clkgen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    rv_dx_top i_dut (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .instr_ready_o (instr_ready),
        .res_o         (res),
        .res_valid_o   (res_valid),
        .res_ready_i   (res_ready)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic stop_on_error(string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(string name, logic [127:0] got, logic [127:0] exp);
        if (got !== exp) begin
            $display("FAIL at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "simulation stopped");
        end
    endtask

    // R-type, alt selects SUB or SRA
    function automatic instr_t op_reg(logic [2:0] f3, logic alt, logic [4:0] rs2,
                                      logic [4:0] rs1, logic [4:0] rd);
        logic [6:0] f7;
        f7 = (alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    // I-type, shifts take a 5-bit shamt under funct7
    function automatic instr_t op_imm(logic [2:0] f3, logic alt, logic [4:0] rs1,
                                      logic [4:0] rd, logic [11:0] imm);
        logic [11:0] field;
        field = imm;
        if (f3 == 3'd1 || f3 == 3'd5) begin
            field = {(alt && f3 == 3'd5) ? 7'h20 : 7'h00, imm[4:0]};
        end
        return {field, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic instr_t random_instr(int reg_bits);
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [19:0] upper;
        logic        alt;
        instr_t      ins;
        kind  = 3'(rand_bits(3));
        f3    = 3'(rand_bits(3));
        rd    = 5'(rand_bits(reg_bits));
        rs1   = 5'(rand_bits(reg_bits));
        rs2   = 5'(rand_bits(reg_bits));
        upper = 20'(rand_bits(20));
        alt   = rand_bits(1) != 0;
        if (kind < 3'd3) begin
            ins = op_reg(f3, alt, rs2, rs1, rd);
        end else if (kind < 3'd6) begin
            ins = op_imm(f3, alt, rs1, rd, upper[11:0]);
        end else if (kind == 3'd6) begin
            ins = {upper, rd, OPC_LUI};
        end else begin
            ins = {upper, rd, OPC_AUIPC};
        end
        return ins;
    endfunction

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        word_t y;
        case (f3)
            3'd0:    y = alt ? a - b : a + b;
            3'd1:    y = a << b[4:0];
            3'd2:    y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    y = (a < b) ? 32'd1 : 32'd0;
            3'd4:    y = a ^ b;
            3'd5:    y = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    y = a | b;
            default: y = a & b;
        endcase
        return y;
    endfunction

    // Executes one instruction on the model register file
    function automatic wb_pkt_t ref_exec(fetch_pkt_t p);
        wb_pkt_t    r;
        logic [6:0] f7;
        logic [2:0] f3;
        logic [4:0] rd;
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      y;
        logic       ok;
        f7  = p.instr[31:25];
        f3  = p.instr[14:12];
        rd  = p.instr[11:7];
        a   = model_regs[p.instr[19:15]];
        b   = model_regs[p.instr[24:20]];
        imm = {{20{p.instr[31]}}, p.instr[31:20]};
        ok  = 1'b1;
        y   = '0;
        case (p.instr[6:0])
            OPC_OP: begin
                ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                y  = alu_ref(f3, f7 == 7'h20, a, b);
            end
            OPC_OP_IMM: begin
                if (f3 == 3'd1) begin
                    ok = (f7 == 7'h00);
                end else if (f3 == 3'd5) begin
                    ok = (f7 == 7'h00) || (f7 == 7'h20);
                end
                y = alu_ref(f3, f3 == 3'd5 && f7 == 7'h20, a, imm);
            end
            OPC_LUI:   y = {p.instr[31:12], 12'b0};
            OPC_AUIPC: y = p.pc + {p.instr[31:12], 12'b0};
            default:   ok = 1'b0;
        endcase
        r.pc      = p.pc;
        r.illegal = !ok;
        r.wr_en   = ok && (rd != 5'd0);
        r.rd_addr = r.wr_en ? rd : 5'd0;
        r.value   = ok ? y : '0;
        if (r.wr_en) begin
            model_regs[rd] = y;
        end
        return r;
    endfunction

    // Next edge, then drive after a short delay
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        res_ready = stalls_on ? (rand_bits(2) != 0) : 1'b1;
    endtask

    task automatic send(instr_t ins);
        fetch_pkt_t pkt;
        int         gap;
        int         waited;
        pkt.pc    = pc_next;
        pkt.instr = ins;
        gap = 0;
        if (gaps_on && rand_bits(2) == 0) begin
            gap = int'(rand_bits(2));
        end
        repeat (gap) begin
            next_cycle();
            instr_valid = 1'b0;
        end
        next_cycle();
        instr_valid = 1'b1;
        instr       = pkt;
        waited      = 0;
        // Ready is stable by the falling edge
        @(negedge clk);
        while (!instr_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_error("Instruction was never accepted by the DUT");
            end
            next_cycle();
            @(negedge clk);
        end
        exp_q.push_back(ref_exec(pkt));
        pc_next += 4;
    endtask

    // Output side, sampled on the falling edge
    initial begin
        wb_pkt_t exp;
        forever begin
            @(negedge clk);
            if (arst_n) begin
                if (prev_stall) begin
                    compare_value("res_valid_o", 128'(res_valid), 128'(1'b1));
                    compare_value("res_o", 128'(res), 128'(prev_res));
                end
                compare_value("instr_ready_o", 128'(instr_ready), 128'(!res_valid || res_ready));
                if (res_valid && res_ready) begin
                    if (exp_q.size() == 0) begin
                        stop_on_error("DUT offered a result with no instruction outstanding");
                    end else begin
                        exp = exp_q.pop_front();
                        compare_value("res_o.pc", 128'(res.pc), 128'(exp.pc));
                        compare_value("res_o.rd_addr", 128'(res.rd_addr), 128'(exp.rd_addr));
                        compare_value("res_o.value", 128'(res.value), 128'(exp.value));
                        compare_value("res_o.wr_en", 128'(res.wr_en), 128'(exp.wr_en));
                        compare_value("res_o.illegal", 128'(res.illegal), 128'(exp.illegal));
                    end
                end
                prev_stall = res_valid && !res_ready;
                prev_res   = res;
            end
        end
    end

    initial begin
        int         waited;
        logic [4:0] prev_rd;
        logic [4:0] rd;
        logic [2:0] f3;
        instr       = '0;
        instr_valid = 1'b0;
        res_ready   = 1'b1;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        waited = 0;
        while (arst_n !== 1'b1) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_error("Reset was never released");
            end
            @(posedge clk);
        end

        // Idle state and first result latency
        @(negedge clk);
        compare_value("res_valid_o", 128'(res_valid), 128'(1'b0));
        compare_value("instr_ready_o", 128'(instr_ready), 128'(1'b1));
        send(op_imm(3'd0, 1'b0, 5'd0, 5'd1, 12'd5));
        next_cycle();
        instr_valid = 1'b0;
        @(negedge clk);
        compare_value("res_valid_o", 128'(res_valid), 128'(1'b0));
        next_cycle();
        @(negedge clk);
        compare_value("res_valid_o", 128'(res_valid), 128'(1'b1));

        // Random mix over x0..x7 with input gaps
        gaps_on = 1'b1;
        for (int i = 0; i < 200; i++) begin
            send(random_instr(3));
        end

        // Dependent chain, back to back
        gaps_on = 1'b0;
        prev_rd = 5'd1;
        for (int i = 0; i < 40; i++) begin
            rd = 5'(rand_bits(3)) | 5'd1;
            f3 = 3'(rand_bits(3));
            if (i % 2 == 0) begin
                send(op_reg(f3, rand_bits(1) != 0, prev_rd, prev_rd, rd));
            end else begin
                send(op_imm(f3, rand_bits(1) != 0, prev_rd, rd, 12'(rand_bits(12))));
            end
            prev_rd = rd;
        end

        // Output back-pressure
        gaps_on   = 1'b1;
        stalls_on = 1'b1;
        for (int i = 0; i < 200; i++) begin
            send(random_instr(4));
        end

        // LUI, AUIPC, x0 writes, illegal encodings
        send({20'habcde, 5'd5, OPC_LUI});
        send({20'h00012, 5'd6, OPC_AUIPC});
        send(op_reg(3'd0, 1'b0, 5'd6, 5'd5, 5'd7));
        send(op_imm(3'd0, 1'b0, 5'd5, 5'd0, 12'd123));
        send(op_reg(3'd0, 1'b0, 5'd5, 5'd0, 5'd1));
        send(32'h0000_2083);
        send({7'h01, 5'd5, 5'd6, 3'd0, 5'd1, OPC_OP});
        send({7'h20, 5'd3, 5'd5, 3'd1, 5'd1, OPC_OP_IMM});
        send({7'h10, 5'd3, 5'd5, 3'd5, 5'd1, OPC_OP_IMM});
        send(op_reg(3'd6, 1'b0, 5'd0, 5'd1, 5'd2));

        // Drain
        stalls_on = 1'b0;
        next_cycle();
        instr_valid = 1'b0;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                stop_on_error("Outstanding results never left the DUT");
            end
            next_cycle();
        end
        repeat (4) next_cycle();

        $display("Test completed successfully");
        $finish;
    end
endmodule

// ==== all.f ====
+incdir+hw
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_pipe_reg_d_e.sv
hw/rv_alu.sv
hw/rv_execute.sv
hw/rv_dx_top.sv
sim/tb_clkgen.sv
sim/tb_rv_dx.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tb_rv_dx
FILELIST := all.f
FLAGS    := --binary --timing --assert -j 0
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || { echo "Simulation did not finish"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
